// ==== rtl/calcPkg.sv ====
package calcPkg;

	// one operand magnitude as typed on the switches
	typedef logic [7:0] operandT;

	// wide enough for 255 * 255
	typedef logic [15:0] resultT;

	typedef logic [3:0] digitT;

	typedef enum logic [1:0] {
		opAdd,
		opSub,
		opMul
	} opT;

	// operands as latched when an operation key is accepted
	typedef struct packed {
		operandT a;
		logic signA;
		operandT b;
		logic signB;
		opT op;
	} operandsS;

	// sign is set for a negative result
	typedef struct packed {
		resultT magnitude;
		logic sign;
	} resultS;

	localparam int operandDigits = 3;
	localparam int resultDigits = 5;

endpackage

// ==== rtl/lcdPkg.sv ====
package lcdPkg;

	typedef logic [7:0] lcdByteT;

	typedef struct packed {
		logic rs;
		logic rw;
		logic en;
		lcdByteT data;
	} lcdBusS;

	// HD44780 commands, 8-bit bus with two lines
	localparam lcdByteT cmdFunctionSet = 8'h38;
	localparam lcdByteT cmdDisplayOn = 8'h0F;
	localparam lcdByteT cmdClear = 8'h01;
	localparam lcdByteT cmdEntryMode = 8'h06;
	localparam lcdByteT cmdLine2 = 8'hC0;
	localparam int functionSetRepeats = 4;

	localparam lcdByteT chSpace = 8'h20;
	localparam lcdByteT chMinus = 8'h2D;
	localparam lcdByteT chPlus = 8'h2B;
	localparam lcdByteT chStar = 8'h2A;
	localparam lcdByteT chZero = 8'h30;

	localparam int lineLength = 16;

	// board values for the clock on the real hardware
	localparam int defEnHighCycles = 125000;
	localparam int defEnLowCycles = 250000;
	localparam int defPowerUpCycles = 2250000;

	typedef enum logic [2:0] {
		powerUp,
		initCmds,
		idle,
		writeExpr,
		writeResult
	} seqStateT;

endpackage

// ==== rtl/keyDetect.sv ====
`timescale 1ns/10ps

module keyDetect (
	input logic CLK,
	input logic rst,
	input logic addKey,
	input logic subKey,
	input logic mulKey,
	input logic equalKey,
	output logic addPress,
	output logic subPress,
	output logic mulPress,
	output logic equalPress
);

	logic [3:0] keyLevel;
	logic [3:0] seenLow;
	logic [3:0] pressPulse;

	assign keyLevel = {addKey, subKey, mulKey, equalKey};

	// keys are active low, so a press completes when the level returns high
	always_ff @(posedge CLK) begin
		if (rst) begin
			seenLow <= '0;
			pressPulse <= '0;
		end else begin
			seenLow <= ~keyLevel;
			pressPulse <= seenLow & keyLevel;
		end
	end

	assign addPress = pressPulse[3];
	assign subPress = pressPulse[2];
	assign mulPress = pressPulse[1];
	assign equalPress = pressPulse[0];

	for (genvar i = 0; i < 4; i++) begin : pulseCheck
		assert property (@(posedge CLK) disable iff (rst) pressPulse[i] |=> !pressPulse[i]);
	end

endmodule

// ==== rtl/signMagAlu.sv ====
`timescale 1ns/10ps

module signMagAlu (
	input logic CLK,
	input logic rst,
	input logic calcStart,
	input calcPkg::opT op,
	input calcPkg::operandT operandA,
	input calcPkg::operandT operandB,
	input logic signA,
	input logic signB,
	output calcPkg::operandsS operands,
	output calcPkg::resultS result
);

	logic computeNext;
	logic signBEff;
	calcPkg::resultT wideA;
	calcPkg::resultT wideB;
	calcPkg::resultS nextResult;

	always_ff @(posedge CLK) begin
		if (calcStart) begin
			operands <= '{a: operandA, signA: signA, b: operandB, signB: signB, op: op};
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			computeNext <= 1'b0;
		end else begin
			computeNext <= calcStart;
		end
	end

	always_ff @(posedge CLK) begin
		if (computeNext) begin
			result <= nextResult;
		end
	end

	assign wideA = calcPkg::resultT'(operands.a);
	assign wideB = calcPkg::resultT'(operands.b);

	// subtraction is an add with B's sign flipped
	assign signBEff = (operands.op == calcPkg::opSub) ? !operands.signB : operands.signB;

	always_comb begin
		if (operands.op == calcPkg::opMul) begin
			nextResult.magnitude = wideA * wideB;
			nextResult.sign = operands.signA ^ operands.signB;
		end else if (operands.signA == signBEff) begin
			nextResult.magnitude = wideA + wideB;
			nextResult.sign = operands.signA;
		end else if (operands.a > operands.b) begin
			nextResult.magnitude = wideA - wideB;
			nextResult.sign = operands.signA;
		end else if (operands.b > operands.a) begin
			nextResult.magnitude = wideB - wideA;
			nextResult.sign = signBEff;
		end else begin
			// equal magnitudes cancel to a positive zero
			nextResult.magnitude = '0;
			nextResult.sign = 1'b0;
		end
	end

endmodule

// ==== rtl/bcdDigits.sv ====
`timescale 1ns/10ps

module bcdDigits #(
	parameter int Width = 8,
	parameter int Digits = 3
) (
	input logic [Width-1:0] value,
	output calcPkg::digitT [Digits-1:0] digits
);

	// digits[Digits-1] is the most significant place
	always_comb begin
		for (int i = Digits - 1; i >= 0; i--) begin
			digits[i] = calcPkg::digitT'((value / (10 ** i)) % 10);
		end
	end

endmodule

// ==== rtl/lcdWriter.sv ====
`timescale 1ns/10ps

module lcdWriter #(
	parameter int EnHighCycles = lcdPkg::defEnHighCycles,
	parameter int EnLowCycles = lcdPkg::defEnLowCycles
) (
	input logic CLK,
	input logic rst,
	input logic byteStart,
	input logic rs,
	input lcdPkg::lcdByteT data,
	output logic byteDone,
	output lcdPkg::lcdBusS lcd
);

	typedef enum logic [1:0] {
		writerIdle,
		writerHigh,
		writerLow
	} writerStateT;

	writerStateT state;
	logic [$clog2(EnHighCycles + EnLowCycles + 1)-1:0] count;

	// the byte stays on the bus through both phases, the display samples it when en falls
	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= writerIdle;
			count <= '0;
			lcd <= '0;
		end else begin
			case (state)
				writerIdle: begin
					if (byteStart) begin
						lcd.rs <= rs;
						lcd.data <= data;
						lcd.en <= 1'b1;
						count <= '0;
						state <= writerHigh;
					end
				end
				writerHigh: begin
					if (count == EnHighCycles - 1) begin
						lcd.en <= 1'b0;
						count <= '0;
						state <= writerLow;
					end else begin
						count <= count + 1'b1;
					end
				end
				writerLow: begin
					if (count == EnLowCycles - 1) begin
						count <= '0;
						state <= writerIdle;
					end else begin
						count <= count + 1'b1;
					end
				end
				default: state <= writerIdle;
			endcase
		end
	end

	assign byteDone = (state == writerLow) && (count == EnLowCycles - 1);

	assert property (@(posedge CLK) disable iff (rst) byteStart |-> state == writerIdle);
	assert property (@(posedge CLK) disable iff (rst) !lcd.rw);

endmodule

// ==== rtl/lcdSequencer.sv ====
`timescale 1ns/10ps

module lcdSequencer #(
	parameter int PowerUpCycles = lcdPkg::defPowerUpCycles
) (
	input logic CLK,
	input logic rst,
	input logic addPress,
	input logic subPress,
	input logic mulPress,
	input logic equalPress,
	output logic calcStart,
	output calcPkg::opT op,
	input calcPkg::operandsS operands,
	input calcPkg::digitT [1:0][calcPkg::operandDigits-1:0] operandText,
	input calcPkg::digitT [calcPkg::resultDigits-1:0] resultText,
	input logic resultSign,
	output logic byteStart,
	output logic rs,
	output lcdPkg::lcdByteT data,
	input logic byteDone
);

	lcdPkg::seqStateT state;
	logic [$clog2(PowerUpCycles + 1)-1:0] powerCount;
	logic [$clog2(lcdPkg::lineLength + 1)-1:0] charIdx;
	logic waitDone;
	logic opShown;
	logic opPress;
	int lastIdx;

	function automatic lcdPkg::lcdByteT signChar(input logic sign);
		return sign ? lcdPkg::chMinus : lcdPkg::chSpace;
	endfunction

	function automatic lcdPkg::lcdByteT digitChar(input calcPkg::digitT digit);
		return lcdPkg::chZero + lcdPkg::lcdByteT'(digit);
	endfunction

	function automatic lcdPkg::lcdByteT opChar(input calcPkg::opT opSel);
		case (opSel)
			calcPkg::opSub: return lcdPkg::chMinus;
			calcPkg::opMul: return lcdPkg::chStar;
			default: return lcdPkg::chPlus;
		endcase
	endfunction

	assign opPress = addPress | subPress | mulPress;
	assign calcStart = (state == lcdPkg::idle) && opPress;

	always_comb begin
		if (addPress) begin
			op = calcPkg::opAdd;
		end else if (subPress) begin
			op = calcPkg::opSub;
		end else if (mulPress) begin
			op = calcPkg::opMul;
		end else begin
			op = calcPkg::opAdd;
		end
	end

	// index 0 of an expression or result run is the leading command
	always_comb begin
		case (state)
			lcdPkg::initCmds: lastIdx = lcdPkg::functionSetRepeats + 2;
			lcdPkg::writeExpr: lastIdx = lcdPkg::lineLength;
			default: lastIdx = calcPkg::resultDigits + 1;
		endcase
	end

	always_comb begin
		int pos;
		int opPos;
		int signBPos;
		pos = int'(charIdx) - 1;
		opPos = lcdPkg::lineLength / 2 - 1;
		signBPos = lcdPkg::lineLength - calcPkg::operandDigits - 2;
		rs = 1'b1;
		data = lcdPkg::chSpace;
		case (state)
			lcdPkg::initCmds: begin
				rs = 1'b0;
				if (charIdx < lcdPkg::functionSetRepeats) begin
					data = lcdPkg::cmdFunctionSet;
				end else if (charIdx == lcdPkg::functionSetRepeats) begin
					data = lcdPkg::cmdDisplayOn;
				end else if (charIdx == lcdPkg::functionSetRepeats + 1) begin
					data = lcdPkg::cmdClear;
				end else begin
					data = lcdPkg::cmdEntryMode;
				end
			end
			lcdPkg::writeExpr: begin
				if (charIdx == 0) begin
					rs = 1'b0;
					data = lcdPkg::cmdClear;
				end else if (pos == 0) begin
					data = signChar(operands.signA);
				end else if (pos <= calcPkg::operandDigits) begin
					data = digitChar(operandText[0][calcPkg::operandDigits - pos]);
				end else if (pos == opPos) begin
					data = opChar(operands.op);
				end else if (pos == signBPos) begin
					data = signChar(operands.signB);
				end else if (pos > signBPos && pos <= signBPos + calcPkg::operandDigits) begin
					data = digitChar(operandText[1][signBPos + calcPkg::operandDigits - pos]);
				end
			end
			lcdPkg::writeResult: begin
				if (charIdx == 0) begin
					rs = 1'b0;
					data = lcdPkg::cmdLine2;
				end else if (charIdx == 1) begin
					data = signChar(resultSign);
				end else begin
					data = digitChar(resultText[calcPkg::resultDigits + 1 - int'(charIdx)]);
				end
			end
			default: ;
		endcase
	end

	assign byteStart = (state inside {lcdPkg::initCmds, lcdPkg::writeExpr, lcdPkg::writeResult})
		&& !waitDone;

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= lcdPkg::powerUp;
			powerCount <= '0;
			charIdx <= '0;
			waitDone <= 1'b0;
			opShown <= 1'b0;
		end else begin
			case (state)
				lcdPkg::powerUp: begin
					if (powerCount == PowerUpCycles - 1) begin
						state <= lcdPkg::initCmds;
					end else begin
						powerCount <= powerCount + 1'b1;
					end
				end
				lcdPkg::idle: begin
					if (opPress) begin
						opShown <= 1'b1;
						state <= lcdPkg::writeExpr;
					end else if (equalPress && opShown) begin
						state <= lcdPkg::writeResult;
					end
				end
				default: begin
					// only one byte is in flight and the next goes out after byteDone
					if (!waitDone) begin
						waitDone <= 1'b1;
					end else if (byteDone) begin
						waitDone <= 1'b0;
						if (charIdx == lastIdx) begin
							charIdx <= '0;
							state <= lcdPkg::idle;
						end else begin
							charIdx <= charIdx + 1'b1;
						end
					end
				end
			endcase
		end
	end

	// the writer may only finish a byte that this sequencer has started
	assert property (@(posedge CLK) disable iff (rst) byteDone |-> waitDone);

endmodule

// ==== rtl/lcdCalcTop.sv ====
`timescale 1ns/10ps

module lcdCalcTop #(
	parameter int EnHighCycles = lcdPkg::defEnHighCycles,
	parameter int EnLowCycles = lcdPkg::defEnLowCycles,
	parameter int PowerUpCycles = lcdPkg::defPowerUpCycles
) (
	input logic CLK,
	input logic rst,
	input logic addKey,
	input logic subKey,
	input logic mulKey,
	input logic equalKey,
	input calcPkg::operandT operandA,
	input calcPkg::operandT operandB,
	input logic signA,
	input logic signB,
	output lcdPkg::lcdBusS lcd
);

	logic addPress;
	logic subPress;
	logic mulPress;
	logic equalPress;
	logic calcStart;
	calcPkg::opT op;
	calcPkg::operandsS operands;
	calcPkg::resultS result;
	calcPkg::digitT [1:0][calcPkg::operandDigits-1:0] operandText;
	calcPkg::digitT [calcPkg::resultDigits-1:0] resultText;
	logic byteStart;
	logic byteRs;
	logic byteDone;
	lcdPkg::lcdByteT byteData;

	keyDetect keys (
		.CLK(CLK),
		.rst(rst),
		.addKey(addKey),
		.subKey(subKey),
		.mulKey(mulKey),
		.equalKey(equalKey),
		.addPress(addPress),
		.subPress(subPress),
		.mulPress(mulPress),
		.equalPress(equalPress)
	);

	signMagAlu alu (
		.CLK(CLK),
		.rst(rst),
		.calcStart(calcStart),
		.op(op),
		.operandA(operandA),
		.operandB(operandB),
		.signA(signA),
		.signB(signB),
		.operands(operands),
		.result(result)
	);

	bcdDigits #(
		.Width($bits(calcPkg::operandT)),
		.Digits(calcPkg::operandDigits)
	) digitsA (
		.value(operands.a),
		.digits(operandText[0])
	);

	bcdDigits #(
		.Width($bits(calcPkg::operandT)),
		.Digits(calcPkg::operandDigits)
	) digitsB (
		.value(operands.b),
		.digits(operandText[1])
	);

	bcdDigits #(
		.Width($bits(calcPkg::resultT)),
		.Digits(calcPkg::resultDigits)
	) digitsResult (
		.value(result.magnitude),
		.digits(resultText)
	);

	lcdSequencer #(
		.PowerUpCycles(PowerUpCycles)
	) sequencer (
		.CLK(CLK),
		.rst(rst),
		.addPress(addPress),
		.subPress(subPress),
		.mulPress(mulPress),
		.equalPress(equalPress),
		.calcStart(calcStart),
		.op(op),
		.operands(operands),
		.operandText(operandText),
		.resultText(resultText),
		.resultSign(result.sign),
		.byteStart(byteStart),
		.rs(byteRs),
		.data(byteData),
		.byteDone(byteDone)
	);

	lcdWriter #(
		.EnHighCycles(EnHighCycles),
		.EnLowCycles(EnLowCycles)
	) writer (
		.CLK(CLK),
		.rst(rst),
		.byteStart(byteStart),
		.rs(byteRs),
		.data(byteData),
		.byteDone(byteDone),
		.lcd(lcd)
	);

endmodule

// ==== tests/lcdCalcTb.sv ====
`timescale 1ns/10ps

module lcdCalcTb;

	localparam int clkPeriod = 100;
	localparam int drvDelay = 10;
	localparam int resetCycles = 4;
	localparam int EnHighCycles = 2;
	localparam int EnLowCycles = 3;
	localparam int PowerUpCycles = 10;
	localparam int writeCycles = EnHighCycles + EnLowCycles;
	localparam int fixedRows = 14;
	localparam int randomRows = 6;
	localparam int writesPerRow = 30;
	localparam int marginCycles = 1500;
	localparam int watchdogCycles =
		(fixedRows + randomRows) * writesPerRow * writeCycles + marginCycles;

	typedef struct packed {
		calcPkg::opT op;
		calcPkg::operandT a;
		logic signA;
		calcPkg::operandT b;
		logic signB;
		logic withEquals;
	} rowS;

	logic CLK;
	logic rst;
	logic addKey;
	logic subKey;
	logic mulKey;
	logic equalKey;
	calcPkg::operandT operandA;
	calcPkg::operandT operandB;
	logic signA;
	logic signB;
	lcdPkg::lcdBusS lcd;
	logic lcdEn;

	rowS rows[$];
	logic capRs[$];
	lcdPkg::lcdByteT capData[$];
	int errorCount = 0;
	int unsigned lcgState = 40;

	lcdCalcTop #(
		.EnHighCycles(EnHighCycles),
		.EnLowCycles(EnLowCycles),
		.PowerUpCycles(PowerUpCycles)
	) uut (
		.CLK(CLK),
		.rst(rst),
		.addKey(addKey),
		.subKey(subKey),
		.mulKey(mulKey),
		.equalKey(equalKey),
		.operandA(operandA),
		.operandB(operandB),
		.signA(signA),
		.signB(signB),
		.lcd(lcd)
	);

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	task automatic stopOnError(input string what);
		errorCount++;
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	initial begin
		#(watchdogCycles * clkPeriod);
		stopOnError($sformatf("the run timed out after %0d clock cycles", watchdogCycles));
	end

	// the display latches a byte on the falling edge of en
	assign lcdEn = lcd.en;

	always @(negedge lcdEn) begin
		if (!rst) begin
			capRs.push_back(lcd.rs);
			capData.push_back(lcd.data);
		end
	end

	always @(posedge CLK) begin
		if (!rst && lcd.rw !== 1'b0) begin
			stopOnError("the rw line of the LCD bus was driven high");
		end
	end

	task automatic checkByte(input string name, input lcdPkg::lcdByteT got,
		input lcdPkg::lcdByteT expected);
		if (got !== expected) begin
			stopOnError($sformatf("[FAIL] %t %s: got %h, expected %h", $realtime, name, got,
				expected));
		end
	endtask

	task automatic checkRs(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			stopOnError($sformatf("[FAIL] %t %s: got %b, expected %b", $realtime, name, got,
				expected));
		end
	endtask

	task automatic checkResult(input string name, input calcPkg::resultS got,
		input calcPkg::resultS expected);
		if (got !== expected) begin
			stopOnError($sformatf("[FAIL] %t %s: got %s%0d, expected %s%0d", $realtime, name,
				got.sign ? "-" : "+", got.magnitude, expected.sign ? "-" : "+",
				expected.magnitude));
		end
	endtask

	function automatic int unsigned nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic appendRow(input calcPkg::opT op, input int a, input logic sa, input int b,
		input logic sb, input logic withEquals);
		rowS r;
		r.op = op;
		r.a = calcPkg::operandT'(a);
		r.signA = sa;
		r.b = calcPkg::operandT'(b);
		r.signB = sb;
		r.withEquals = withEquals;
		rows.push_back(r);
	endtask

	function automatic lcdPkg::lcdByteT signOf(input logic negative);
		return negative ? lcdPkg::chMinus : lcdPkg::chSpace;
	endfunction

	function automatic lcdPkg::lcdByteT digitAt(input int value, input int place);
		return lcdPkg::chZero + lcdPkg::lcdByteT'((value / place) % 10);
	endfunction

	// layout of line 1 is sign, three digits, padding, operator, padding, sign, three digits
	function automatic lcdPkg::lcdByteT exprChar(input rowS r, input int pos);
		case (pos)
			0: return signOf(r.signA);
			1: return digitAt(r.a, 100);
			2: return digitAt(r.a, 10);
			3: return digitAt(r.a, 1);
			7: begin
				case (r.op)
					calcPkg::opAdd: return lcdPkg::chPlus;
					calcPkg::opSub: return lcdPkg::chMinus;
					default: return lcdPkg::chStar;
				endcase
			end
			11: return signOf(r.signB);
			12: return digitAt(r.b, 100);
			13: return digitAt(r.b, 10);
			14: return digitAt(r.b, 1);
			default: return lcdPkg::chSpace;
		endcase
	endfunction

	function automatic calcPkg::resultS expectedResult(input rowS r);
		calcPkg::resultS res;
		logic negB;
		int a;
		int b;
		a = r.a;
		b = r.b;
		negB = (r.op == calcPkg::opSub) ? ~r.signB : r.signB;
		if (r.op == calcPkg::opMul) begin
			res.magnitude = calcPkg::resultT'(a * b);
			res.sign = r.signA ^ r.signB;
		end else if (r.signA == negB) begin
			res.magnitude = calcPkg::resultT'(a + b);
			res.sign = r.signA;
		end else if (a == b) begin
			res.magnitude = '0;
			res.sign = 1'b0;
		end else if (a > b) begin
			res.magnitude = calcPkg::resultT'(a - b);
			res.sign = r.signA;
		end else begin
			res.magnitude = calcPkg::resultT'(b - a);
			res.sign = negB;
		end
		return res;
	endfunction

	function automatic logic [3:0] keyMask(input calcPkg::opT op);
		case (op)
			calcPkg::opAdd: return 4'b1000;
			calcPkg::opSub: return 4'b0100;
			default: return 4'b0010;
		endcase
	endfunction

	task automatic clearCaptures();
		capRs.delete();
		capData.delete();
	endtask

	// the mask is ordered add, sub, mul, equals and a set bit pulls that key low
	task automatic pressKeys(input logic [3:0] lowMask, input int holdCycles);
		@(posedge CLK);
		#drvDelay;
		{addKey, subKey, mulKey, equalKey} = ~lowMask;
		repeat (holdCycles) @(posedge CLK);
		if (capData.size() != 0) begin
			stopOnError("LCD writes appeared while a key was still held low");
		end
		#drvDelay;
		{addKey, subKey, mulKey, equalKey} = 4'hF;
	endtask

	task automatic waitCaptures(input int count);
		int cycles;
		cycles = 0;
		while (capData.size() < count) begin
			@(posedge CLK);
			cycles++;
			if (cycles > count * writeCycles * 2 + 50) begin
				stopOnError($sformatf("expected %0d LCD writes but only %0d arrived", count,
					capData.size()));
			end
		end
		// long enough for one more byte to show up if the sequencer ran on
		repeat (writeCycles + 3) @(posedge CLK);
		if (capData.size() != count) begin
			stopOnError($sformatf("expected %0d LCD writes but %0d arrived", count,
				capData.size()));
		end
	endtask

	task automatic checkInit();
		lcdPkg::lcdByteT initCmds [7];
		initCmds = '{lcdPkg::cmdFunctionSet, lcdPkg::cmdFunctionSet, lcdPkg::cmdFunctionSet,
			lcdPkg::cmdFunctionSet, lcdPkg::cmdDisplayOn, lcdPkg::cmdClear,
			lcdPkg::cmdEntryMode};
		waitCaptures(7);
		for (int i = 0; i < 7; i++) begin
			checkRs($sformatf("init write %0d rs", i), capRs[i], 1'b0);
			checkByte($sformatf("init write %0d data", i), capData[i], initCmds[i]);
		end
		clearCaptures();
	endtask

	task automatic checkExpression(input rowS r);
		waitCaptures(lcdPkg::lineLength + 1);
		checkRs("clear command rs", capRs[0], 1'b0);
		checkByte("clear command", capData[0], lcdPkg::cmdClear);
		for (int pos = 0; pos < lcdPkg::lineLength; pos++) begin
			checkRs($sformatf("expression char %0d rs", pos), capRs[pos + 1], 1'b1);
			checkByte($sformatf("expression char %0d", pos), capData[pos + 1], exprChar(r, pos));
		end
		clearCaptures();
	endtask

	task automatic checkResultLine(input rowS r);
		calcPkg::resultS seen;
		int magnitude;
		waitCaptures(7);
		checkRs("line 2 command rs", capRs[0], 1'b0);
		checkByte("line 2 command", capData[0], lcdPkg::cmdLine2);
		for (int i = 1; i < 7; i++) begin
			checkRs($sformatf("result char %0d rs", i - 1), capRs[i], 1'b1);
		end
		if (capData[1] == lcdPkg::chMinus) begin
			seen.sign = 1'b1;
		end else if (capData[1] == lcdPkg::chSpace) begin
			seen.sign = 1'b0;
		end else begin
			stopOnError($sformatf("result sign character %h is neither a minus nor a space",
				capData[1]));
		end
		magnitude = 0;
		for (int i = 2; i < 7; i++) begin
			if (capData[i] < lcdPkg::chZero || capData[i] > lcdPkg::chZero + 8'd9) begin
				stopOnError($sformatf("result character %h is not a decimal digit", capData[i]));
			end
			magnitude = magnitude * 10 + int'(capData[i] - lcdPkg::chZero);
		end
		seen.magnitude = calcPkg::resultT'(magnitude);
		checkResult("result", seen, expectedResult(r));
		clearCaptures();
	endtask

	task automatic runRow(input rowS r, input int holdCycles);
		@(posedge CLK);
		#drvDelay;
		operandA = r.a;
		signA = r.signA;
		operandB = r.b;
		signB = r.signB;
		pressKeys(keyMask(r.op), holdCycles);
		checkExpression(r);
		if (r.withEquals) begin
			pressKeys(4'b0001, 2);
			checkResultLine(r);
		end
	endtask

	initial begin
		int unsigned rndA;
		int unsigned rndB;
		$timeformat(-9, 1, " ns", 0);
		rst = 1'b1;
		{addKey, subKey, mulKey, equalKey} = 4'hF;
		operandA = '0;
		operandB = '0;
		signA = 1'b0;
		signB = 1'b0;

		// op, A, signA, B, signB, equals follows
		appendRow(calcPkg::opAdd, 12, 1'b0, 34, 1'b0, 1'b1);
		appendRow(calcPkg::opAdd, 100, 1'b1, 55, 1'b0, 1'b1);
		appendRow(calcPkg::opAdd, 20, 1'b0, 200, 1'b1, 1'b1);
		appendRow(calcPkg::opAdd, 77, 1'b0, 77, 1'b1, 1'b1);
		appendRow(calcPkg::opAdd, 255, 1'b1, 255, 1'b1, 1'b1);
		appendRow(calcPkg::opSub, 50, 1'b0, 30, 1'b0, 1'b1);
		appendRow(calcPkg::opSub, 30, 1'b0, 50, 1'b0, 1'b1);
		appendRow(calcPkg::opSub, 10, 1'b1, 10, 1'b1, 1'b1);
		appendRow(calcPkg::opSub, 200, 1'b1, 100, 1'b0, 1'b1);
		appendRow(calcPkg::opMul, 255, 1'b0, 255, 1'b0, 1'b1);
		appendRow(calcPkg::opMul, 12, 1'b1, 0, 1'b0, 1'b1);
		appendRow(calcPkg::opMul, 7, 1'b1, 9, 1'b1, 1'b1);
		appendRow(calcPkg::opAdd, 5, 1'b0, 6, 1'b0, 1'b0);
		appendRow(calcPkg::opSub, 1, 1'b0, 2, 1'b0, 1'b1);
		for (int i = 0; i < randomRows; i++) begin
			rndA = nextRandom();
			rndB = nextRandom();
			appendRow(calcPkg::opT'((rndA >> 24) % 3), int'(rndA[23:16]), rndA[15],
				int'(rndB[23:16]), rndB[15], 1'b1);
		end

		repeat (resetCycles) @(posedge CLK);
		#drvDelay;
		rst = 1'b0;
		checkRs("lcd.en after reset", lcd.en, 1'b0);
		checkRs("lcd.rs after reset", lcd.rs, 1'b0);
		checkRs("lcd.rw after reset", lcd.rw, 1'b0);
		checkByte("lcd.data after reset", lcd.data, '0);

		checkInit();

		// equals with no operation shown yet must leave the display alone
		pressKeys(4'b0001, 2);
		repeat (4 * writeCycles + 10) @(posedge CLK);
		if (capData.size() != 0) begin
			stopOnError("the equals key wrote to the LCD before any operation");
		end

		foreach (rows[i]) begin
			runRow(rows[i], (i == 0) ? 20 : 2);
		end

		if (errorCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
rtl/calcPkg.sv
rtl/lcdPkg.sv
rtl/keyDetect.sv
rtl/signMagAlu.sv
rtl/bcdDigits.sv
rtl/lcdWriter.sv
rtl/lcdSequencer.sv
rtl/lcdCalcTop.sv
tests/lcdCalcTb.sv

// ==== Bender.yml ====
package:
  name: lcd_calc

sources:
  - rtl/calcPkg.sv
  - rtl/lcdPkg.sv
  - rtl/keyDetect.sv
  - rtl/signMagAlu.sv
  - rtl/bcdDigits.sv
  - rtl/lcdWriter.sv
  - rtl/lcdSequencer.sv
  - rtl/lcdCalcTop.sv
  - target: test
    files:
      - tests/lcdCalcTb.sv
